// ==== Makefile ====
TOP := tb_cart_loader

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing --top-module $(TOP) -f files.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// ==== cart_header_scan.sv ====
`default_nettype none
`timescale 1ns/100ps

module cart_header_scan (
	input  wire                      clk_sys,
	input  wire                      RESET,
	input  cart_pkg::ioctl_bus_t     ioctl,
	input  wire                      cart_download,
	output cart_pkg::region_flags_t  hdr_flags,
	output logic                     hdr_ready
);
	import cart_pkg::*;

	logic          dl_q;
	byte_t         lo;
	byte_t         hi;
	logic [3:0]    hrgn;
	region_flags_t flags_next;

	// Flag for a region letter
	function automatic region_flags_t letter_flags(input byte_t c);
		region_flags_t f;
		f = '0;
		case (c)
			"J": f.j = 1'b1;
			"U": f.u = 1'b1;
			"E": f.e = 1'b1;
			default: ;
		endcase
		return f;
	endfunction

	assign lo   = ioctl.data[7:0];
	assign hi   = ioctl.data[15:8];
	assign hrgn = lo[3:0] - 4'd7;  // 'A'..'F' down to 10..15

	always_comb begin
		flags_next = hdr_flags;
		if (ioctl.addr == HDR_REGION_ADDR) begin
			if (letter_flags(lo) != '0) begin
				flags_next = hdr_flags | letter_flags(lo);
			end else if (lo >= "0" && lo <= "9") begin
				flags_next.e = lo[3];
				flags_next.u = lo[2];
				flags_next.j = lo[0];
			end else if (lo >= "A" && lo <= "F") begin
				flags_next.e = hrgn[3];
				flags_next.u = hrgn[2];
				flags_next.j = hrgn[0];
			end
			flags_next = flags_next | letter_flags(hi);  // Second letter of the pair
		end else if (ioctl.addr == HDR_REGION2_ADDR) begin
			flags_next = hdr_flags | letter_flags(lo);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_q      <= 1'b0;
			hdr_flags <= '0;
			hdr_ready <= 1'b0;
		end else begin
			dl_q <= cart_download;
			if (cart_download && !dl_q) hdr_flags <= '0;  // New image
			if (!cart_download && dl_q) hdr_ready <= 1'b0;
			if (ioctl.wr && cart_download) begin
				hdr_flags <= flags_next;
				if (ioctl.addr == HDR_END_ADDR) hdr_ready <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== cart_loader_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module cart_loader_top (
	input  wire                     clk_sys,
	input  wire                     RESET,
	input  cart_pkg::ioctl_bus_t    ioctl,
	input  wire                     ioctl_download,
	input  cart_pkg::byte_t         ioctl_index,
	input  cart_pkg::region_auto_t  auto_mode,
	input  cart_pkg::region_prio_t  prio,
	input  wire                     rom_wr_ack,
	output logic                    ioctl_wait,
	output logic                    rom_wr_req,
	output cart_pkg::addr_t         rom_wr_addr,
	output cart_pkg::word_t         rom_wr_data,
	output cart_pkg::addr_t         rom_size,
	output cart_pkg::region_t       region_req,
	output logic                    region_set,
	output cart_pkg::quirk_flags_t  quirks,
	output cart_pkg::gun_cfg_t      gun_cfg,
	output cart_pkg::cheat_code_t   cheat_code,
	output logic                    cheat_strobe,
	output logic                    cheat_clear
);
	import cart_pkg::*;

	logic          code_download;
	logic          cart_download;
	region_flags_t hdr_flags;
	logic          hdr_ready;

	// All ones index carries cheat codes
	assign code_download = ioctl_download & (&ioctl_index);
	assign cart_download = ioctl_download & ~(&ioctl_index);

	//////////////////// ROM side
	cart_header_scan u_cart_header_scan (
		.clk_sys, .RESET, .ioctl, .cart_download, .hdr_flags, .hdr_ready
	);

	cart_quirk_lookup u_cart_quirk_lookup (
		.clk_sys, .RESET, .ioctl, .cart_download, .quirks, .gun_cfg
	);

	rom_write_pacer u_rom_write_pacer (
		.clk_sys, .RESET, .ioctl, .cart_download, .rom_wr_ack,
		.rom_wr_req, .rom_wr_addr, .rom_wr_data, .ioctl_wait, .rom_size
	);

	region_select u_region_select (
		.clk_sys, .RESET, .hdr_flags, .hdr_ready, .auto_mode, .prio,
		.ioctl_index, .region_req, .region_set
	);

	//////////////////// Cheat side
	cheat_code_loader u_cheat_code_loader (
		.clk_sys, .RESET, .ioctl, .code_download,
		.cheat_code, .cheat_strobe, .cheat_clear
	);

endmodule

`default_nettype wire

// ==== cart_pkg.sv ====
`default_nettype none

package cart_pkg;

	//////////////////// Widths
	typedef logic [24:0] addr_t;   // Loader byte address
	typedef logic [15:0] word_t;
	typedef logic [7:0]  byte_t;

	// One loader write strobe
	typedef struct packed {
		logic  wr;
		addr_t addr;
		word_t data;
	} ioctl_bus_t;

	//////////////////// Region
	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_t;

	typedef struct packed {
		logic j;
		logic u;
		logic e;
	} region_flags_t;

	typedef enum logic [1:0] {
		AUTO_EXT,
		AUTO_HEADER,
		AUTO_OFF
	} region_auto_t;

	// Search order with the fallback first
	typedef enum logic [1:0] {
		PRIO_UEJ,
		PRIO_EUJ,
		PRIO_UJE,
		PRIO_JUE
	} region_prio_t;

	//////////////////// Cartridge quirks
	typedef struct packed {
		logic sram;
		logic eeprom;
		logic noram;
		logic fifo;
		logic svp;
		logic fmbusy;
	} quirk_flags_t;

	typedef struct packed {
		logic  gun_type;
		byte_t sensor_delay;
	} gun_cfg_t;

	// Big endian words straight from the code file
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	//////////////////// Header offsets
	localparam addr_t HDR_REGION_ADDR  = 25'h1F0;
	localparam addr_t HDR_REGION2_ADDR = 25'h1F2;
	localparam addr_t HDR_END_ADDR     = 25'h200;

	localparam addr_t ID_FIRST_ADDR = 25'h182;
	localparam addr_t ID_LAST_ADDR  = 25'h18A;
	localparam addr_t ID_CHECK_ADDR = 25'h18C;

	localparam byte_t GUN_DELAY_DEFAULT = 8'd44;

endpackage

`default_nettype wire

// ==== cart_quirk_lookup.sv ====
`default_nettype none
`timescale 1ns/100ps

module cart_quirk_lookup (
	input  wire                     clk_sys,
	input  wire                     RESET,
	input  cart_pkg::ioctl_bus_t    ioctl,
	input  wire                     cart_download,
	output cart_pkg::quirk_flags_t  quirks,
	output cart_pkg::gun_cfg_t      gun_cfg
);
	import cart_pkg::*;

	logic         dl_q;
	logic         cart_wr;
	logic [63:0]  cart_id;  // Eight ASCII chars
	quirk_flags_t quirk_hit;
	gun_cfg_t     gun_next;

	assign cart_wr = ioctl.wr & cart_download;

	// Product code from byte swapped header words
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			case (ioctl.addr)
				ID_FIRST_ADDR: cart_id[63:56] <= ioctl.data[15:8];
				25'h184:       cart_id[55:40] <= {ioctl.data[7:0], ioctl.data[15:8]};
				25'h186:       cart_id[39:24] <= {ioctl.data[7:0], ioctl.data[15:8]};
				25'h188:       cart_id[23:8]  <= {ioctl.data[7:0], ioctl.data[15:8]};
				ID_LAST_ADDR:  cart_id[7:0]   <= ioctl.data[7:0];
				default: ;
			endcase
		end
	end

	//////////////////// Lookup tables
	always_comb begin
		quirk_hit = '0;
		case (cart_id)
			"T-081276": quirk_hit.sram   = 1'b1;
			"MK-1215 ": quirk_hit.eeprom = 1'b1;
			"T-113016": quirk_hit.noram  = 1'b1;  // Fake RAM check
			"T-89016 ": quirk_hit.fifo   = 1'b1;
			"MK-1229 ": quirk_hit.svp    = 1'b1;  // Virtua Racing
			"T-35036 ": quirk_hit.fmbusy = 1'b1;
			default: ;
		endcase
	end

	always_comb begin
		gun_next.gun_type     = 1'b0;
		gun_next.sensor_delay = GUN_DELAY_DEFAULT;
		case (cart_id)
			"T-95096-": begin  // Justifier type gun
				gun_next.gun_type     = 1'b1;
				gun_next.sensor_delay = 8'd52;
			end
			"MK-1533 ": gun_next.sensor_delay = 8'd100;
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_q                 <= 1'b0;
			quirks               <= '0;
			gun_cfg.gun_type     <= 1'b0;
			gun_cfg.sensor_delay <= GUN_DELAY_DEFAULT;
		end else begin
			dl_q <= cart_download;
			if (cart_download && !dl_q) quirks <= '0;
			if (cart_wr && ioctl.addr == ID_CHECK_ADDR) begin
				quirks  <= quirks | quirk_hit;
				gun_cfg <= gun_next;
			end
		end
	end

endmodule

`default_nettype wire

// ==== cheat_code_loader.sv ====
`default_nettype none
`timescale 1ns/100ps

module cheat_code_loader (
	input  wire                    clk_sys,
	input  wire                    RESET,
	input  cart_pkg::ioctl_bus_t   ioctl,
	input  wire                    code_download,
	output cart_pkg::cheat_code_t  cheat_code,
	output logic                   cheat_strobe,
	output logic                   cheat_clear
);
	import cart_pkg::*;

	logic code_wr;

	assign code_wr = ioctl.wr & code_download;

	// Low word first within each field
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl.addr[3:0])
				4'd0:  cheat_code.flags[15:0]    <= ioctl.data;
				4'd2:  cheat_code.flags[31:16]   <= ioctl.data;
				4'd4:  cheat_code.addr[15:0]     <= ioctl.data;
				4'd6:  cheat_code.addr[31:16]    <= ioctl.data;
				4'd8:  cheat_code.compare[15:0]  <= ioctl.data;
				4'd10: cheat_code.compare[31:16] <= ioctl.data;
				4'd12: cheat_code.replace[15:0]  <= ioctl.data;
				4'd14: cheat_code.replace[31:16] <= ioctl.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_strobe <= 1'b0;
			cheat_clear  <= 1'b0;
		end else begin
			cheat_strobe <= code_wr && (ioctl.addr[3:0] == 4'd14);  // Record complete
			cheat_clear  <= code_wr && (ioctl.addr == '0);          // Start of code list
		end
	end

endmodule

`default_nettype wire

// ==== files.f ====
cart_pkg.sv
cart_header_scan.sv
cart_quirk_lookup.sv
region_select.sv
cheat_code_loader.sv
rom_write_pacer.sv
cart_loader_top.sv
tb_cart_loader.sv

// ==== region_select.sv ====
`default_nettype none
`timescale 1ns/100ps

module region_select (
	input  wire                      clk_sys,
	input  wire                      RESET,
	input  cart_pkg::region_flags_t  hdr_flags,
	input  wire                      hdr_ready,
	input  cart_pkg::region_auto_t   auto_mode,
	input  cart_pkg::region_prio_t   prio,
	input  cart_pkg::byte_t          ioctl_index,
	output cart_pkg::region_t        region_req,
	output logic                     region_set
);
	import cart_pkg::*;

	logic ready_q;

	function automatic logic has_flag(input region_t r, input region_flags_t f);
		case (r)
			REGION_JP: return f.j;
			REGION_US: return f.u;
			REGION_EU: return f.e;
			default:   return 1'b0;
		endcase
	endfunction

	// First present region in the search order
	function automatic region_t pick_region(input region_flags_t f, input region_prio_t p);
		logic [5:0] order;  // First region searched in the top bits
		case (p)
			PRIO_UEJ: order = {REGION_US, REGION_EU, REGION_JP};
			PRIO_EUJ: order = {REGION_EU, REGION_US, REGION_JP};
			PRIO_UJE: order = {REGION_US, REGION_JP, REGION_EU};
			default:  order = {REGION_JP, REGION_US, REGION_EU};
		endcase
		if (has_flag(region_t'(order[5:4]), f)) return region_t'(order[5:4]);
		else if (has_flag(region_t'(order[3:2]), f)) return region_t'(order[3:2]);
		else if (has_flag(region_t'(order[1:0]), f)) return region_t'(order[1:0]);
		return region_t'(order[5:4]);  // Nothing found
	endfunction

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ready_q    <= 1'b0;
			region_req <= REGION_JP;
			region_set <= 1'b0;
		end else begin
			ready_q <= hdr_ready;
			if (hdr_ready && !ready_q) begin
				case (auto_mode)
					AUTO_HEADER: begin
						region_req <= pick_region(hdr_flags, prio);
						region_set <= 1'b1;
					end
					AUTO_EXT: begin  // Extension bits from the index
						region_req <= region_t'(ioctl_index[7:6]);
						region_set <= |ioctl_index;
					end
					default: ;
				endcase
			end
			if (!hdr_ready && ready_q) region_set <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== rom_write_pacer.sv ====
`default_nettype none
`timescale 1ns/100ps

module rom_write_pacer (
	input  wire                   clk_sys,
	input  wire                   RESET,
	input  cart_pkg::ioctl_bus_t  ioctl,
	input  wire                   cart_download,
	input  wire                   rom_wr_ack,
	output logic                  rom_wr_req,
	output cart_pkg::addr_t       rom_wr_addr,
	output cart_pkg::word_t       rom_wr_data,
	output logic                  ioctl_wait,
	output cart_pkg::addr_t       rom_size
);
	import cart_pkg::*;

	logic dl_q;
	logic cart_wr;

	assign cart_wr = ioctl.wr & cart_download;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_q       <= 1'b0;
			rom_wr_req <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			dl_q <= cart_download;
			if (cart_wr) begin
				ioctl_wait <= 1'b1;
				rom_wr_req <= ~rom_wr_req;  // Toggle request
			end else if (ioctl_wait && rom_wr_req == rom_wr_ack) begin
				ioctl_wait <= 1'b0;  // Memory caught up
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			rom_wr_addr <= {1'b0, ioctl.addr[24:1]};            // Word address
			rom_wr_data <= {ioctl.data[7:0], ioctl.data[15:8]};
		end
		if (dl_q && !cart_download) rom_size <= ioctl.addr;
	end

endmodule

`default_nettype wire

// ==== tb_cart_loader.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_cart_loader;
	import cart_pkg::*;

	localparam logic [15:0] LFSR_SEED      = 16'd63207;
	localparam int          TIMEOUT_CYCLES = 20000;  // About 4x the ~5000 stimulus cycles

	logic         clk_sys;
	logic         RESET;
	ioctl_bus_t   ioctl;
	logic         ioctl_download;
	byte_t        ioctl_index;
	region_auto_t auto_mode;
	region_prio_t prio;
	logic         rom_wr_ack;
	logic         ioctl_wait;
	logic         rom_wr_req;
	addr_t        rom_wr_addr;
	word_t        rom_wr_data;
	addr_t        rom_size;
	region_t      region_req;
	logic         region_set;
	quirk_flags_t quirks;
	gun_cfg_t     gun_cfg;
	cheat_code_t  cheat_code;
	logic         cheat_strobe;
	logic         cheat_clear;

	logic        cart_dl;
	logic        code_dl;
	int          mismatch_count = 0;
	int          protocol_count = 0;
	int          strobe_count   = 0;
	int          cycle_count;
	string       test_name;
	logic [15:0] mem_lfsr;
	logic [15:0] word_lfsr;
	byte_t       ext_idx[4] = '{8'h41, 8'h80, 8'h00, 8'h3C};

	cart_loader_top u_cart_loader_top (
		.clk_sys, .RESET, .ioctl, .ioctl_download, .ioctl_index, .auto_mode, .prio,
		.rom_wr_ack, .ioctl_wait, .rom_wr_req, .rom_wr_addr, .rom_wr_data, .rom_size,
		.region_req, .region_set, .quirks, .gun_cfg, .cheat_code, .cheat_strobe,
		.cheat_clear
	);

	always #5 clk_sys = ~clk_sys;

	// Index 0xFF carries cheat codes
	assign code_dl = ioctl_download && (ioctl_index == 8'hFF);
	assign cart_dl = ioctl_download && (ioctl_index != 8'hFF);

	always @(negedge clk_sys) begin
		if (!RESET && cheat_strobe) strobe_count++;
	end

	//////////////////// Handshake rules
	wait_after_write: assert property (@(posedge clk_sys) disable iff (RESET)
		(ioctl.wr && cart_dl) |=> ioctl_wait)
	else begin
		protocol_count++;
		$display("ioctl_wait did not rise after a cart write at %0t", $time);
	end

	wait_holds: assert property (@(posedge clk_sys) disable iff (RESET)
		(ioctl_wait && rom_wr_req != rom_wr_ack) |=> ioctl_wait)
	else begin
		protocol_count++;
		$display("ioctl_wait dropped before the memory ack at %0t", $time);
	end

	wait_releases: assert property (@(posedge clk_sys) disable iff (RESET)
		(ioctl_wait && rom_wr_req == rom_wr_ack && !ioctl.wr) |=> !ioctl_wait)
	else begin
		protocol_count++;
		$display("ioctl_wait stayed high after the memory ack at %0t", $time);
	end

	no_req_on_code: assert property (@(posedge clk_sys) disable iff (RESET)
		code_dl |-> $stable(rom_wr_req))
	else begin
		protocol_count++;
		$display("ROM request toggled during a cheat download at %0t", $time);
	end

	//////////////////// Helpers
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11
	endfunction

	task automatic take_bits(inout logic [15:0] state, input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			state = lfsr_next(state);
			bits  = {bits[30:0], state[0]};
		end
	endtask

	task automatic check_value(input string what, input logic [127:0] exp,
		input logic [127:0] act);
		assert (exp == act) else begin
			mismatch_count++;
			$display("MISMATCH %s %s: expected %0h, actual %0h", test_name, what, exp, act);
		end
	endtask

	// Header bytes as they sit in the ROM image
	function automatic byte_t hdr_byte(input addr_t x, input logic [63:0] id,
		input logic [23:0] rgn);
		int k;
		k = int'(x);
		if (k >= 'h183 && k <= 'h18A) return id[63 - 8*(k - 'h183) -: 8];
		if (k >= 'h1F0 && k <= 'h1F2) return rgn[23 - 8*(k - 'h1F0) -: 8];
		if (k < 'h200) return " ";
		return x[7:0] ^ x[15:8] ^ x[23:16] ^ byte_t'(x[24]);  // Filler past the header
	endfunction

	function automatic word_t header_word(input addr_t a, input logic [63:0] id,
		input logic [23:0] rgn);
		return {hdr_byte(a + 25'd1, id, rgn), hdr_byte(a, id, rgn)};
	endfunction

	function automatic region_t region_of(input byte_t c);
		case (c)
			"J":     return REGION_JP;
			"U":     return REGION_US;
			default: return REGION_EU;
		endcase
	endfunction

	function automatic logic flag_of(input byte_t c, input region_flags_t f);
		case (c)
			"J":     return f.j;
			"U":     return f.u;
			default: return f.e;
		endcase
	endfunction

	// Region letters anywhere, digit or hex code in the first byte
	function automatic region_flags_t expected_flags(input logic [23:0] rgn);
		region_flags_t f;
		byte_t         c;
		logic [3:0]    v;
		f = '0;
		c = rgn[23:16];
		v = 4'(c - "0");
		if (c >= "A" && c <= "F") v = 4'(c - "A" + 8'd10);
		// E is a region letter before it is a hex digit
		if (c != "E" && ((c >= "0" && c <= "9") || (c >= "A" && c <= "F"))) begin
			f.e = v[3];
			f.u = v[2];
			f.j = v[0];
		end
		for (int i = 0; i < 3; i++) begin
			c = rgn[23 - 8*i -: 8];
			if (c == "J") f.j = 1'b1;
			if (c == "U") f.u = 1'b1;
			if (c == "E") f.e = 1'b1;
		end
		return f;
	endfunction

	function automatic region_t expected_region(input region_flags_t f, input region_prio_t p);
		string   order;
		region_t r;
		case (p)
			PRIO_UEJ: order = "UEJ";
			PRIO_EUJ: order = "EUJ";
			PRIO_UJE: order = "UJE";
			default:  order = "JUE";
		endcase
		r = region_of(order[0]);  // Fallback when no flag
		for (int i = 2; i >= 0; i--) begin
			if (flag_of(order[i], f)) r = region_of(order[i]);
		end
		return r;
	endfunction

	function automatic logic [23:0] region_variant(input int v);
		case (v)
			0:       return "JU ";
			1:       return "E U";
			2:       return "9  ";
			3:       return "A  ";
			4:       return "UE ";
			default: return "   ";
		endcase
	endfunction

	function automatic logic [63:0] quirk_id(input int k);
		case (k)
			0:       return "T-081276";
			1:       return "MK-1215 ";
			2:       return "T-113016";
			3:       return "T-89016 ";
			4:       return "MK-1229 ";
			5:       return "T-35036 ";
			6:       return "T-95096-";
			7:       return "MK-1533 ";
			default: return "T-12345 ";
		endcase
	endfunction

	function automatic quirk_flags_t expected_quirks(input int k);
		quirk_flags_t q;
		q = '0;
		case (k)
			0:       q.sram   = 1'b1;
			1:       q.eeprom = 1'b1;
			2:       q.noram  = 1'b1;
			3:       q.fifo   = 1'b1;
			4:       q.svp    = 1'b1;
			5:       q.fmbusy = 1'b1;
			default: ;
		endcase
		return q;
	endfunction

	function automatic gun_cfg_t expected_gun(input int k);
		gun_cfg_t g;
		g.gun_type     = (k == 6);
		g.sensor_delay = (k == 6) ? 8'd52 : (k == 7) ? 8'd100 : 8'd44;
		return g;
	endfunction

	//////////////////// Loader side
	task automatic write_word(input addr_t a, input word_t d);
		logic old_req;
		@(negedge clk_sys);
		old_req    = rom_wr_req;
		ioctl.wr   = 1'b1;
		ioctl.addr = a;
		ioctl.data = d;
		@(negedge clk_sys);
		ioctl.wr = 1'b0;
		if (cart_dl) begin
			check_value("rom_wr_req", 128'(!old_req), 128'(rom_wr_req));
			check_value("rom_wr_addr", 128'(a >> 1), 128'(rom_wr_addr));
			check_value("rom_wr_data", 128'({d[7:0], d[15:8]}), 128'(rom_wr_data));
		end
		while (ioctl_wait) @(negedge clk_sys);  // Back-pressure
	endtask

	task automatic load_cart(input byte_t idx, input logic [63:0] id, input logic [23:0] rgn);
		addr_t a;
		@(negedge clk_sys);
		ioctl_index    = idx;
		ioctl_download = 1'b1;
		for (int k = 0; k < 7; k++) begin  // Product code words
			a = addr_t'(32'h180 + 2*k);
			write_word(a, header_word(a, id, rgn));
		end
		write_word(HDR_REGION_ADDR, header_word(HDR_REGION_ADDR, id, rgn));
		write_word(HDR_REGION2_ADDR, header_word(HDR_REGION2_ADDR, id, rgn));
		for (int k = 0; k < 4; k++) begin  // Ends at 0x206
			a = addr_t'(32'h200 + 2*k);
			write_word(a, header_word(a, id, rgn));
		end
	endtask

	task automatic end_download();
		@(negedge clk_sys);
		ioctl_download = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic end_cart();
		end_download();
		check_value("rom_size", 128'(25'h206), 128'(rom_size));
	endtask

	// Memory acks each request toggle after 1 to 8 cycles
	initial begin
		logic [31:0] bits;
		mem_lfsr   = LFSR_SEED;
		rom_wr_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (rom_wr_req != rom_wr_ack) begin
				take_bits(mem_lfsr, 3, bits);
				repeat (bits[2:0]) @(negedge clk_sys);
				rom_wr_ack = rom_wr_req;
			end
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("Timeout after %0d cycles: %0d mismatches, %0d protocol errors",
			cycle_count, mismatch_count, protocol_count);
		$display("Test failed");
		$finish;
	end

	//////////////////// Test sequence
	initial begin
		logic [31:0] bits;
		word_t       words[8];
		cheat_code_t exp_code;
		region_t     r0;
		logic [23:0] rgn;
		clk_sys        = 1'b0;
		RESET          = 1'b1;
		ioctl          = '0;
		ioctl_download = 1'b0;
		ioctl_index    = 8'h00;
		auto_mode      = AUTO_HEADER;
		prio           = PRIO_UEJ;
		word_lfsr      = LFSR_SEED;
		test_name      = "reset";
		repeat (2) @(negedge clk_sys);
		RESET = 1'b0;
		check_value("ioctl_wait", 128'(0), 128'(ioctl_wait));
		check_value("rom_wr_req", 128'(0), 128'(rom_wr_req));
		check_value("region_set", 128'(0), 128'(region_set));
		check_value("quirks", 128'(0), 128'(quirks));
		check_value("gun_cfg", 128'(expected_gun(8)), 128'(gun_cfg));
		check_value("cheat_strobe", 128'(0), 128'(cheat_strobe));
		check_value("cheat_clear", 128'(0), 128'(cheat_clear));

		test_name = "header_region";
		for (int p = 0; p < 4; p++) begin
			for (int v = 0; v < 6; v++) begin
				prio = region_prio_t'(p);
				rgn  = region_variant(v);
				load_cart(8'h00, quirk_id(8), rgn);
				check_value("region_set", 128'(1), 128'(region_set));
				check_value("region_req", 128'(expected_region(expected_flags(rgn), prio)),
					128'(region_req));
				end_cart();
				check_value("region_set after download", 128'(0), 128'(region_set));
			end
		end

		test_name = "extension_mode";
		auto_mode = AUTO_EXT;
		for (int k = 0; k < 4; k++) begin
			load_cart(ext_idx[k], quirk_id(8), "E  ");
			check_value("region_req", 128'(ext_idx[k][7:6]), 128'(region_req));
			check_value("region_set", 128'(|ext_idx[k]), 128'(region_set));
			end_cart();
		end

		test_name = "auto_off";
		auto_mode = AUTO_OFF;
		r0        = region_req;
		load_cart(8'h80, quirk_id(8), "UE ");
		check_value("region_set", 128'(0), 128'(region_set));
		check_value("region_req", 128'(r0), 128'(region_req));
		end_cart();

		test_name = "quirk_lookup";
		auto_mode = AUTO_HEADER;
		for (int k = 0; k < 9; k++) begin
			load_cart(8'h00, quirk_id(k), "J  ");
			check_value("quirks", 128'(expected_quirks(k)), 128'(quirks));
			check_value("gun_cfg", 128'(expected_gun(k)), 128'(gun_cfg));
			end_cart();
		end

		test_name = "cheat_codes";
		@(negedge clk_sys);
		ioctl_index    = 8'hFF;
		ioctl_download = 1'b1;
		for (int k = 0; k < 8; k++) begin
			take_bits(word_lfsr, 16, bits);
			words[k] = bits[15:0];
			write_word(addr_t'(2*k), words[k]);
			check_value("cheat_clear", 128'(k == 0), 128'(cheat_clear));
			check_value("cheat_strobe", 128'(k == 7), 128'(cheat_strobe));
		end
		// Low word first in each 32-bit field
		exp_code = {words[1], words[0], words[3], words[2],
			words[5], words[4], words[7], words[6]};
		check_value("cheat_code", exp_code, cheat_code);
		end_download();
		check_value("cheat_strobe pulses", 128'(1), 128'(strobe_count));

		$display("Checks done: %0d mismatches, %0d protocol errors",
			mismatch_count, protocol_count);
		if (mismatch_count == 0 && protocol_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
